// ==== source/simd_alu_config.svh ====
// geometry of the simd alu datapath, word width and byte lane split
`ifndef SIMD_ALU_CONFIG_SVH
`define SIMD_ALU_CONFIG_SVH

// full data word as seen by the register file
`define SIMD_ALU_XLEN 32

// narrowest lane, one byte
`define SIMD_ALU_LANE_W 8

// number of narrowest lanes per word
`define SIMD_ALU_LANES (`SIMD_ALU_XLEN / `SIMD_ALU_LANE_W)

`endif

// ==== source/simd_alu_pkg.sv ====
// shared simd alu types for opcodes, lane partition, result routing and lane views
`default_nettype none

`include "simd_alu_config.svh"

package simd_alu_pkg;

  // operations handled by the alu
  typedef enum logic [4:0] {
    ALU_ADD  = 5'h00,
    ALU_SUB  = 5'h01,
    ALU_AND  = 5'h02,
    ALU_OR   = 5'h03,
    ALU_XOR  = 5'h04,
    // lane compares producing all-ones or all-zeros masks
    ALU_EQ   = 5'h05,
    ALU_NE   = 5'h06,
    ALU_GTS  = 5'h07,
    ALU_GTU  = 5'h08,
    ALU_GES  = 5'h09,
    ALU_GEU  = 5'h0a,
    ALU_LTS  = 5'h0b,
    ALU_LTU  = 5'h0c,
    ALU_LES  = 5'h0d,
    ALU_LEU  = 5'h0e,
    // scalar set-less-than
    ALU_SLTS = 5'h0f,
    ALU_SLTU = 5'h10,
    ALU_MIN  = 5'h11,
    ALU_MINU = 5'h12,
    ALU_MAX  = 5'h13,
    ALU_MAXU = 5'h14
  } alu_op_e;

  // lane partition of the word
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  // one flag per byte lane
  typedef logic [`SIMD_ALU_LANES-1:0] lane_mask_t;

  // same word addressed whole, as halves or as bytes
  typedef union packed {
    logic [`SIMD_ALU_XLEN-1:0]                        word;
    logic [1:0][2*`SIMD_ALU_LANE_W-1:0]               lane16;
    logic [`SIMD_ALU_LANES-1:0][`SIMD_ALU_LANE_W-1:0] lane8;
  } simd_word_u;

  // source of the final result
  typedef enum logic [2:0] {
    RES_ADDER      = 3'd0,
    RES_LOGIC      = 3'd1,
    RES_CMP_MASK   = 3'd2,
    RES_CMP_SCALAR = 3'd3,
    RES_MINMAX     = 3'd4
  } res_sel_e;

  typedef enum logic [1:0] {
    LOGIC_AND = 2'd0,
    LOGIC_OR  = 2'd1,
    LOGIC_XOR = 2'd2
  } logic_op_e;

endpackage

`default_nettype wire

// ==== source/simd_alu_decode_stage.sv ====
// first simd alu stage that classifies the opcode and registers the operands
`default_nettype none

`include "simd_alu_config.svh"

module simd_alu_decode_stage
  import simd_alu_pkg::*;
(
  input  logic                      clk,
  input  logic                      arst_n_i,
  input  logic                      enable_i,
  input  alu_op_e                   operator_i,
  input  vec_mode_e                 vector_mode_i,
  input  logic [`SIMD_ALU_XLEN-1:0] operand_a_i,
  input  logic [`SIMD_ALU_XLEN-1:0] operand_b_i,
  output logic                      valid_o,
  output vec_mode_e                 vector_mode_o,
  output logic [`SIMD_ALU_XLEN-1:0] operand_a_o,
  output logic [`SIMD_ALU_XLEN-1:0] operand_b_o,
  output logic                      negate_o,
  output lane_mask_t                cmp_signed_o,
  output alu_op_e                   cmp_kind_o,
  output res_sel_e                  res_sel_o,
  output logic                      do_min_o,
  output logic_op_e                 logic_op_o
);

  vec_mode_e  vec_mode;
  logic       negate;
  logic       signed_op;
  logic       do_min;
  lane_mask_t cmp_signed;
  res_sel_e   res_sel;
  logic_op_e  logic_op;

  assign do_min = (operator_i == ALU_MIN) || (operator_i == ALU_MINU);

  // opcode classification
  always_comb begin
    vec_mode  = vector_mode_i;
    negate    = 1'b0;
    signed_op = 1'b0;
    res_sel   = RES_ADDER;
    logic_op  = LOGIC_AND;
    case (operator_i)
      ALU_SUB: negate = 1'b1;
      ALU_AND: res_sel = RES_LOGIC;
      ALU_OR: begin
        res_sel  = RES_LOGIC;
        logic_op = LOGIC_OR;
      end
      ALU_XOR: begin
        res_sel  = RES_LOGIC;
        logic_op = LOGIC_XOR;
      end
      ALU_EQ, ALU_NE, ALU_GTU, ALU_GEU, ALU_LTU, ALU_LEU: begin
        negate  = 1'b1;
        res_sel = RES_CMP_MASK;
      end
      ALU_GTS, ALU_GES, ALU_LTS, ALU_LES: begin
        negate    = 1'b1;
        signed_op = 1'b1;
        res_sel   = RES_CMP_MASK;
      end
      // scalar compares always look at the full word
      ALU_SLTS, ALU_SLTU: begin
        negate    = 1'b1;
        signed_op = (operator_i == ALU_SLTS);
        vec_mode  = VEC_MODE32;
        res_sel   = RES_CMP_SCALAR;
      end
      ALU_MINU, ALU_MAXU: res_sel = RES_MINMAX;
      ALU_MIN, ALU_MAX: begin
        signed_op = 1'b1;
        res_sel   = RES_MINMAX;
      end
      default: ;
    endcase
  end

  // only the top byte of each lane carries the sign
  always_comb begin
    cmp_signed = '0;
    if (signed_op) begin
      case (vec_mode)
        VEC_MODE8:  cmp_signed = 4'b1111;
        VEC_MODE16: cmp_signed = 4'b1010;
        default:    cmp_signed = 4'b1000;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o       <= 1'b0;
      vector_mode_o <= VEC_MODE32;
      operand_a_o   <= '0;
      operand_b_o   <= '0;
      negate_o      <= 1'b0;
      cmp_signed_o  <= '0;
      cmp_kind_o    <= ALU_ADD;
      res_sel_o     <= RES_ADDER;
      do_min_o      <= 1'b0;
      logic_op_o    <= LOGIC_AND;
    end else begin
      valid_o <= enable_i;
      // operands and controls only move with a new operation
      if (enable_i) begin
        vector_mode_o <= vec_mode;
        operand_a_o   <= operand_a_i;
        operand_b_o   <= operand_b_i;
        negate_o      <= negate;
        cmp_signed_o  <= cmp_signed;
        cmp_kind_o    <= operator_i;
        res_sel_o     <= res_sel;
        do_min_o      <= do_min;
        logic_op_o    <= logic_op;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/simd_alu_execute_stage.sv ====
// second simd alu stage with the lane partitioned adder and the byte comparators
`default_nettype none

`include "simd_alu_config.svh"

module simd_alu_execute_stage
  import simd_alu_pkg::*;
(
  input  logic                      clk,
  input  logic                      arst_n_i,
  input  logic                      valid_i,
  input  vec_mode_e                 vector_mode_i,
  input  logic [`SIMD_ALU_XLEN-1:0] operand_a_i,
  input  logic [`SIMD_ALU_XLEN-1:0] operand_b_i,
  input  logic                      negate_i,
  input  lane_mask_t                cmp_signed_i,
  input  alu_op_e                   cmp_kind_i,
  input  res_sel_e                  res_sel_i,
  input  logic                      do_min_i,
  input  logic_op_e                 logic_op_i,
  output logic                      valid_o,
  output simd_word_u                sum_o,
  output lane_mask_t                is_equal_vec_o,
  output lane_mask_t                is_greater_vec_o,
  output simd_word_u                operand_a_o,
  output simd_word_u                operand_b_o,
  output vec_mode_e                 vector_mode_o,
  output alu_op_e                   cmp_kind_o,
  output res_sel_e                  res_sel_o,
  output logic                      do_min_o,
  output logic_op_e                 logic_op_o
);

  // one carry insertion bit below every byte
  localparam int unsigned seg_w   = `SIMD_ALU_LANE_W + 1;
  localparam int unsigned adder_w = `SIMD_ALU_LANES * seg_w;

  simd_word_u         op_a, op_b, adder_op_b, sum;
  lane_mask_t         lane_start, is_equal_vec, is_greater_vec;
  logic [adder_w-1:0] adder_in_a, adder_in_b, adder_out;

  assign op_a       = operand_a_i;
  assign op_b       = operand_b_i;
  assign adder_op_b = negate_i ? ~operand_b_i : operand_b_i;

  ////////////////////////////////////////
  // partitioned adder
  ////////////////////////////////////////

  // bytes that open a lane in the current partition
  always_comb begin
    case (vector_mode_i)
      VEC_MODE8:  lane_start = 4'b1111;
      VEC_MODE16: lane_start = 4'b0101;
      default:    lane_start = 4'b0001;
    endcase
  end

  always_comb begin
    for (int i = 0; i < `SIMD_ALU_LANES; i++) begin
      // 1+1 injects the +1 of a negation, 0+0 kills the carry, 1+0 lets it ripple
      adder_in_a[seg_w*i] = negate_i | ~lane_start[i];
      adder_in_b[seg_w*i] = negate_i & lane_start[i];
      adder_in_a[seg_w*i+1 +: `SIMD_ALU_LANE_W] = op_a.lane8[i];
      adder_in_b[seg_w*i+1 +: `SIMD_ALU_LANE_W] = adder_op_b.lane8[i];
    end
    adder_out = adder_in_a + adder_in_b;
    // drop the insertion bits again
    for (int i = 0; i < `SIMD_ALU_LANES; i++) begin
      sum.lane8[i] = adder_out[seg_w*i+1 +: `SIMD_ALU_LANE_W];
    end
  end

  ////////////////////////////////////////
  // byte comparators
  ////////////////////////////////////////

  // sign extend by one bit only where the byte is a signed lane top
  always_comb begin
    for (int i = 0; i < `SIMD_ALU_LANES; i++) begin
      is_equal_vec[i]   = (op_a.lane8[i] == op_b.lane8[i]);
      is_greater_vec[i] =
        $signed({op_a.lane8[i][`SIMD_ALU_LANE_W-1] & cmp_signed_i[i], op_a.lane8[i]}) >
        $signed({op_b.lane8[i][`SIMD_ALU_LANE_W-1] & cmp_signed_i[i], op_b.lane8[i]});
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o          <= 1'b0;
      sum_o            <= '0;
      is_equal_vec_o   <= '0;
      is_greater_vec_o <= '0;
      operand_a_o      <= '0;
      operand_b_o      <= '0;
      vector_mode_o    <= VEC_MODE32;
      cmp_kind_o       <= ALU_ADD;
      res_sel_o        <= RES_ADDER;
      do_min_o         <= 1'b0;
      logic_op_o       <= LOGIC_AND;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        sum_o            <= sum;
        is_equal_vec_o   <= is_equal_vec;
        is_greater_vec_o <= is_greater_vec;
        operand_a_o      <= op_a;
        operand_b_o      <= op_b;
        vector_mode_o    <= vector_mode_i;
        cmp_kind_o       <= cmp_kind_i;
        res_sel_o        <= res_sel_i;
        do_min_o         <= do_min_i;
        logic_op_o       <= logic_op_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/simd_alu_writeback_stage.sv ====
// third simd alu stage that merges lane flags and registers the selected result
`default_nettype none

`include "simd_alu_config.svh"

module simd_alu_writeback_stage
  import simd_alu_pkg::*;
(
  input  logic                      clk,
  input  logic                      arst_n_i,
  input  logic                      valid_i,
  input  vec_mode_e                 vector_mode_i,
  input  simd_word_u                sum_i,
  input  lane_mask_t                is_equal_vec_i,
  input  lane_mask_t                is_greater_vec_i,
  input  simd_word_u                operand_a_i,
  input  simd_word_u                operand_b_i,
  input  alu_op_e                   cmp_kind_i,
  input  res_sel_e                  res_sel_i,
  input  logic                      do_min_i,
  input  logic_op_e                 logic_op_i,
  output logic                      valid_o,
  output logic [`SIMD_ALU_XLEN-1:0] result_o,
  output logic                      comparison_o
);

  lane_mask_t                is_equal, is_greater, cmp_result, sel_minmax;
  simd_word_u                cmp_mask, minmax;
  logic [`SIMD_ALU_XLEN-1:0] logic_res, result_d;

  ////////////////////////////////////////
  // lane merge
  ////////////////////////////////////////

  // word compare by default, upper byte decides unless equal
  always_comb begin
    is_equal   = {`SIMD_ALU_LANES{&is_equal_vec_i}};
    is_greater = {`SIMD_ALU_LANES{is_greater_vec_i[3] | (is_equal_vec_i[3] &
                 (is_greater_vec_i[2] | (is_equal_vec_i[2] &
                 (is_greater_vec_i[1] | (is_equal_vec_i[1] & is_greater_vec_i[0])))))}};
    case (vector_mode_i)
      VEC_MODE16: begin
        is_equal[1:0]   = {2{is_equal_vec_i[1] & is_equal_vec_i[0]}};
        is_equal[3:2]   = {2{is_equal_vec_i[3] & is_equal_vec_i[2]}};
        is_greater[1:0] = {2{is_greater_vec_i[1] | (is_equal_vec_i[1] & is_greater_vec_i[0])}};
        is_greater[3:2] = {2{is_greater_vec_i[3] | (is_equal_vec_i[3] & is_greater_vec_i[2])}};
      end
      VEC_MODE8: begin
        is_equal   = is_equal_vec_i;
        is_greater = is_greater_vec_i;
      end
      default: ;
    endcase
  end

  // relation per lane
  always_comb begin
    case (cmp_kind_i)
      ALU_NE:                              cmp_result = ~is_equal;
      ALU_GTS, ALU_GTU:                    cmp_result = is_greater;
      ALU_GES, ALU_GEU:                    cmp_result = is_greater | is_equal;
      ALU_LTS, ALU_LTU, ALU_SLTS, ALU_SLTU: cmp_result = ~(is_greater | is_equal);
      ALU_LES, ALU_LEU:                    cmp_result = ~is_greater;
      default:                             cmp_result = is_equal;
    endcase
  end

  // min takes a when not greater, max when greater
  always_comb begin
    sel_minmax = is_greater ^ {`SIMD_ALU_LANES{do_min_i}};
    for (int i = 0; i < `SIMD_ALU_LANES; i++) begin
      minmax.lane8[i]   = sel_minmax[i] ? operand_a_i.lane8[i] : operand_b_i.lane8[i];
      cmp_mask.lane8[i] = {`SIMD_ALU_LANE_W{cmp_result[i]}};
    end
  end

  ////////////////////////////////////////
  // result select
  ////////////////////////////////////////

  always_comb begin
    case (logic_op_i)
      LOGIC_OR:  logic_res = operand_a_i.word | operand_b_i.word;
      LOGIC_XOR: logic_res = operand_a_i.word ^ operand_b_i.word;
      default:   logic_res = operand_a_i.word & operand_b_i.word;
    endcase
  end

  always_comb begin
    case (res_sel_i)
      RES_LOGIC:      result_d = logic_res;
      RES_CMP_MASK:   result_d = cmp_mask.word;
      RES_CMP_SCALAR: result_d = {{(`SIMD_ALU_XLEN-1){1'b0}}, cmp_result[`SIMD_ALU_LANES-1]};
      RES_MINMAX:     result_d = minmax.word;
      default:        result_d = sum_i.word;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o      <= 1'b0;
      result_o     <= '0;
      comparison_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        result_o     <= result_d;
        // top lane flag doubles as the branch compare
        comparison_o <= cmp_result[`SIMD_ALU_LANES-1];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/simd_alu_top.sv ====
// three stage pipelined simd integer alu with decode, execute and writeback
`default_nettype none

`include "simd_alu_config.svh"

module simd_alu_top
  import simd_alu_pkg::*;
(
  input  logic                      clk,
  input  logic                      arst_n_i,
  input  logic                      enable_i,
  input  alu_op_e                   operator_i,
  input  vec_mode_e                 vector_mode_i,
  input  logic [`SIMD_ALU_XLEN-1:0] operand_a_i,
  input  logic [`SIMD_ALU_XLEN-1:0] operand_b_i,
  output logic [`SIMD_ALU_XLEN-1:0] result_o,
  output logic                      comparison_o,
  output logic                      valid_o
);

  // decode to execute
  logic                      dec_valid, dec_negate, dec_do_min;
  logic [`SIMD_ALU_XLEN-1:0] dec_op_a, dec_op_b;
  vec_mode_e                 dec_vec_mode;
  lane_mask_t                dec_cmp_signed;
  alu_op_e                   dec_cmp_kind;
  res_sel_e                  dec_res_sel;
  logic_op_e                 dec_logic_op;

  // execute to writeback
  logic       exe_valid, exe_do_min;
  simd_word_u exe_sum, exe_op_a, exe_op_b;
  lane_mask_t exe_is_equal, exe_is_greater;
  vec_mode_e  exe_vec_mode;
  alu_op_e    exe_cmp_kind;
  res_sel_e   exe_res_sel;
  logic_op_e  exe_logic_op;

  simd_alu_decode_stage i_decode (
    .clk(clk), .arst_n_i(arst_n_i), .enable_i(enable_i),
    .operator_i(operator_i), .vector_mode_i(vector_mode_i),
    .operand_a_i(operand_a_i), .operand_b_i(operand_b_i),
    .valid_o(dec_valid), .vector_mode_o(dec_vec_mode),
    .operand_a_o(dec_op_a), .operand_b_o(dec_op_b),
    .negate_o(dec_negate), .cmp_signed_o(dec_cmp_signed),
    .cmp_kind_o(dec_cmp_kind), .res_sel_o(dec_res_sel),
    .do_min_o(dec_do_min), .logic_op_o(dec_logic_op)
  );

  simd_alu_execute_stage i_execute (
    .clk(clk), .arst_n_i(arst_n_i), .valid_i(dec_valid),
    .vector_mode_i(dec_vec_mode), .operand_a_i(dec_op_a), .operand_b_i(dec_op_b),
    .negate_i(dec_negate), .cmp_signed_i(dec_cmp_signed),
    .cmp_kind_i(dec_cmp_kind), .res_sel_i(dec_res_sel),
    .do_min_i(dec_do_min), .logic_op_i(dec_logic_op),
    .valid_o(exe_valid), .sum_o(exe_sum),
    .is_equal_vec_o(exe_is_equal), .is_greater_vec_o(exe_is_greater),
    .operand_a_o(exe_op_a), .operand_b_o(exe_op_b), .vector_mode_o(exe_vec_mode),
    .cmp_kind_o(exe_cmp_kind), .res_sel_o(exe_res_sel),
    .do_min_o(exe_do_min), .logic_op_o(exe_logic_op)
  );

  simd_alu_writeback_stage i_writeback (
    .clk(clk), .arst_n_i(arst_n_i), .valid_i(exe_valid),
    .vector_mode_i(exe_vec_mode), .sum_i(exe_sum),
    .is_equal_vec_i(exe_is_equal), .is_greater_vec_i(exe_is_greater),
    .operand_a_i(exe_op_a), .operand_b_i(exe_op_b),
    .cmp_kind_i(exe_cmp_kind), .res_sel_i(exe_res_sel),
    .do_min_i(exe_do_min), .logic_op_i(exe_logic_op),
    .valid_o(valid_o), .result_o(result_o), .comparison_o(comparison_o)
  );

endmodule

`default_nettype wire

// ==== verification/simd_alu_tb_model.svh ====
// reference model of the simd alu that computes expected results lane by lane
`ifndef SIMD_ALU_TB_MODEL_SVH
`define SIMD_ALU_TB_MODEL_SVH

// lane width for a partition
function automatic int lane_width(vec_mode_e mode);
  int w;
  case (mode)
    VEC_MODE8:  w = `SIMD_ALU_LANE_W;
    VEC_MODE16: w = 2 * `SIMD_ALU_LANE_W;
    default:    w = `SIMD_ALU_XLEN;
  endcase
  return w;
endfunction

// ops that order lanes as two's complement
function automatic bit is_signed_op(alu_op_e op);
  return op inside {ALU_GTS, ALU_GES, ALU_LTS, ALU_LES, ALU_SLTS, ALU_MIN, ALU_MAX};
endfunction

// ops whose comparison_o is defined
function automatic bit yields_flag(alu_op_e op);
  return op inside {ALU_EQ, ALU_NE, ALU_GTS, ALU_GTU, ALU_GES, ALU_GEU,
                    ALU_LTS, ALU_LTU, ALU_LES, ALU_LEU, ALU_SLTS, ALU_SLTU};
endfunction

// lane idx of a word, zero extended
function automatic logic [`SIMD_ALU_XLEN-1:0] get_lane(simd_word_u u, vec_mode_e mode,
                                                      int idx);
  logic [`SIMD_ALU_XLEN-1:0] v;
  case (mode)
    VEC_MODE8:  v = `SIMD_ALU_XLEN'(u.lane8[idx]);
    VEC_MODE16: v = `SIMD_ALU_XLEN'(u.lane16[idx]);
    default:    v = u.word;
  endcase
  return v;
endfunction

// write lane idx, upper bits of v are dropped
function automatic simd_word_u put_lane(simd_word_u u, vec_mode_e mode, int idx,
                                        logic [`SIMD_ALU_XLEN-1:0] v);
  simd_word_u r;
  r = u;
  case (mode)
    VEC_MODE8:  r.lane8[idx] = v[`SIMD_ALU_LANE_W-1:0];
    VEC_MODE16: r.lane16[idx] = v[2*`SIMD_ALU_LANE_W-1:0];
    default:    r.word = v;
  endcase
  return r;
endfunction

// numeric value of a lane, signed or unsigned on lane width
function automatic longint lane_value(logic [`SIMD_ALU_XLEN-1:0] v, int width, bit is_signed);
  longint val;
  val = longint'({32'b0, v});
  if (is_signed && v[width-1]) begin
    val = val - (longint'(1) << width);
  end
  return val;
endfunction

// relation named by a compare op
function automatic bit lane_relation(alu_op_e op, longint va, longint vb);
  bit rel;
  case (op)
    ALU_EQ:           rel = (va == vb);
    ALU_NE:           rel = (va != vb);
    ALU_GTS, ALU_GTU: rel = (va > vb);
    ALU_GES, ALU_GEU: rel = (va >= vb);
    ALU_LES, ALU_LEU: rel = (va <= vb);
    // lt forms and slt
    default:          rel = (va < vb);
  endcase
  return rel;
endfunction

// top lane relation, slt always on the whole word
function automatic logic model_flag(alu_op_e op, vec_mode_e mode,
                                    logic [`SIMD_ALU_XLEN-1:0] a,
                                    logic [`SIMD_ALU_XLEN-1:0] b);
  simd_word_u ua, ub;
  vec_mode_e  lane_mode;
  int         w;
  int         top;
  bit         sgn;
  ua.word   = a;
  ub.word   = b;
  lane_mode = (op == ALU_SLTS || op == ALU_SLTU) ? VEC_MODE32 : mode;
  w         = lane_width(lane_mode);
  top       = `SIMD_ALU_XLEN / w - 1;
  sgn       = is_signed_op(op);
  return lane_relation(op, lane_value(get_lane(ua, lane_mode, top), w, sgn),
                       lane_value(get_lane(ub, lane_mode, top), w, sgn));
endfunction

// expected result word
function automatic logic [`SIMD_ALU_XLEN-1:0] model_result(alu_op_e op, vec_mode_e mode,
                                                          logic [`SIMD_ALU_XLEN-1:0] a,
                                                          logic [`SIMD_ALU_XLEN-1:0] b);
  simd_word_u ua, ub, res;
  int         w;
  bit         sgn;
  longint     va, vb, lane, mask;
  ua.word  = a;
  ub.word  = b;
  res.word = '0;
  w        = lane_width(mode);
  sgn      = is_signed_op(op);
  mask     = (longint'(1) << w) - 1;
  case (op)
    ALU_AND:            res.word = a & b;
    ALU_OR:             res.word = a | b;
    ALU_XOR:            res.word = a ^ b;
    ALU_SLTS, ALU_SLTU: res.word = `SIMD_ALU_XLEN'(model_flag(op, mode, a, b));
    default: begin
      for (int i = 0; i < `SIMD_ALU_XLEN / w; i++) begin
        va = lane_value(get_lane(ua, mode, i), w, sgn);
        vb = lane_value(get_lane(ub, mode, i), w, sgn);
        case (op)
          ALU_ADD:            lane = va + vb;
          ALU_SUB:            lane = va - vb;
          ALU_MIN, ALU_MINU:  lane = (va < vb) ? va : vb;
          ALU_MAX, ALU_MAXU:  lane = (va > vb) ? va : vb;
          default:            lane = lane_relation(op, va, vb) ? mask : '0;
        endcase
        // wrap within the lane
        lane = lane & mask;
        res  = put_lane(res, mode, i, lane[`SIMD_ALU_XLEN-1:0]);
      end
    end
  endcase
  return res.word;
endfunction

`endif

// ==== verification/simd_alu_tb.sv ====
// testbench for the pipelined simd alu, table of directed and random operations
`default_nettype none

`include "simd_alu_config.svh"

module simd_alu_tb
  import simd_alu_pkg::*;
();

  localparam int clk_period   = 100;
  localparam int reset_cycles = 4;
  localparam int latency      = 3;
  localparam int random_rows  = 200;
  // one idle cycle after every idle_every rows
  localparam int idle_every   = 7;

  logic                      clk;
  logic                      arst_n_i;
  logic                      enable_i;
  alu_op_e                   operator_i;
  vec_mode_e                 vector_mode_i;
  logic [`SIMD_ALU_XLEN-1:0] operand_a_i;
  logic [`SIMD_ALU_XLEN-1:0] operand_b_i;
  logic [`SIMD_ALU_XLEN-1:0] result_o;
  logic                      comparison_o;
  logic                      valid_o;

  // one operation with its expected response
  typedef struct {
    alu_op_e                   op;
    vec_mode_e                 mode;
    logic [`SIMD_ALU_XLEN-1:0] a;
    logic [`SIMD_ALU_XLEN-1:0] b;
    logic [`SIMD_ALU_XLEN-1:0] exp_result;
    logic                      exp_flag;
    bit                        flag_valid;
  } row_t;

  // operation in flight and the cycle its result is due
  typedef struct {
    int row;
    int due;
  } pending_t;

  row_t     rows[$];
  pending_t pending[$];
  int       row_idx;
  int       current_row;
  int       checked;
  int       cycle_cnt = 0;
  int       timeout_limit = 0;

  `include "simd_alu_tb_model.svh"

  simd_alu_top i_simd_alu_top (
    .clk(clk), .arst_n_i(arst_n_i), .enable_i(enable_i),
    .operator_i(operator_i), .vector_mode_i(vector_mode_i),
    .operand_a_i(operand_a_i), .operand_b_i(operand_b_i),
    .result_o(result_o), .comparison_o(comparison_o), .valid_o(valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // failure reporting and compares
  ////////////////////////////////////////

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_result(input string name, input logic [`SIMD_ALU_XLEN-1:0] got,
                              input logic [`SIMD_ALU_XLEN-1:0] exp);
    if (got !== exp) begin
      $display("ERR time=%0t signal=%s got=%h expected=%h row=%0d",
               $time, name, got, exp, current_row);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR time=%0t signal=%s got=%b expected=%b row=%0d",
               $time, name, got, exp, current_row);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  task automatic add_row(input alu_op_e op, input vec_mode_e mode,
                         input logic [`SIMD_ALU_XLEN-1:0] a,
                         input logic [`SIMD_ALU_XLEN-1:0] b);
    row_t r;
    r.op         = op;
    r.mode       = mode;
    r.a          = a;
    r.b          = b;
    r.exp_result = model_result(op, mode, a, b);
    r.exp_flag   = model_flag(op, mode, a, b);
    r.flag_valid = yields_flag(op);
    rows.push_back(r);
  endtask

  task automatic build_directed_rows();
    // carries at the lane boundaries
    add_row(ALU_ADD, VEC_MODE32, 32'h7fff_ffff, 32'h0000_0001);
    add_row(ALU_ADD, VEC_MODE32, 32'hffff_ffff, 32'h0000_0001);
    add_row(ALU_ADD, VEC_MODE16, 32'h0000_ffff, 32'h0000_0001);
    add_row(ALU_ADD, VEC_MODE16, 32'h7fff_8000, 32'h0001_8000);
    add_row(ALU_ADD, VEC_MODE8,  32'hff80_ff7f, 32'h0180_0101);
    add_row(ALU_ADD, VEC_MODE8,  32'h7f7f_7f7f, 32'h0101_0101);
    // borrows at the lane boundaries
    add_row(ALU_SUB, VEC_MODE32, 32'h0000_0000, 32'h0000_0001);
    add_row(ALU_SUB, VEC_MODE32, 32'h8000_0000, 32'h0000_0001);
    add_row(ALU_SUB, VEC_MODE16, 32'h0000_0000, 32'h0001_0001);
    add_row(ALU_SUB, VEC_MODE16, 32'h8000_7fff, 32'h0001_ffff);
    add_row(ALU_SUB, VEC_MODE8,  32'h0080_7f01, 32'h0101_0102);
    // equality, some lanes equal
    add_row(ALU_EQ,  VEC_MODE8,  32'h1234_5678, 32'h12ff_5600);
    add_row(ALU_EQ,  VEC_MODE16, 32'h1234_5678, 32'h1234_5600);
    add_row(ALU_EQ,  VEC_MODE32, 32'hcafe_f00d, 32'hcafe_f00d);
    add_row(ALU_NE,  VEC_MODE16, 32'h1234_5678, 32'h1234_5600);
    // 0x80 against 0x7f, signed and unsigned disagree
    add_row(ALU_GTS, VEC_MODE8,  32'h807f_0001, 32'h7f80_ff00);
    add_row(ALU_GTU, VEC_MODE8,  32'h807f_0001, 32'h7f80_ff00);
    add_row(ALU_GTS, VEC_MODE16, 32'h8000_0001, 32'h7fff_0000);
    add_row(ALU_GTU, VEC_MODE16, 32'h8000_0001, 32'h7fff_0000);
    add_row(ALU_GTS, VEC_MODE32, 32'h8000_0000, 32'h7fff_ffff);
    add_row(ALU_GTU, VEC_MODE32, 32'h8000_0000, 32'h7fff_ffff);
    add_row(ALU_GES, VEC_MODE8,  32'h8012_7f00, 32'h8012_8001);
    add_row(ALU_GEU, VEC_MODE16, 32'h8000_1234, 32'h7fff_1234);
    add_row(ALU_LTS, VEC_MODE8,  32'h807f_0001, 32'h7f80_ff00);
    add_row(ALU_LTU, VEC_MODE8,  32'h807f_0001, 32'h7f80_ff00);
    add_row(ALU_LTS, VEC_MODE32, 32'hffff_ffff, 32'h0000_0000);
    add_row(ALU_LES, VEC_MODE16, 32'h8000_7fff, 32'h8000_8000);
    add_row(ALU_LEU, VEC_MODE8,  32'h00ff_8080, 32'h0000_7f80);
    // scalar set less than
    add_row(ALU_SLTS, VEC_MODE8,  32'hffff_ffff, 32'h0000_0001);
    add_row(ALU_SLTU, VEC_MODE8,  32'hffff_ffff, 32'h0000_0001);
    add_row(ALU_SLTS, VEC_MODE16, 32'h1234_5678, 32'h1234_5678);
    add_row(ALU_SLTU, VEC_MODE32, 32'h0000_0000, 32'h8000_0000);
    // min and max
    add_row(ALU_MIN,  VEC_MODE8,  32'h807f_0102, 32'h7f80_ff02);
    add_row(ALU_MINU, VEC_MODE8,  32'h807f_0102, 32'h7f80_ff02);
    add_row(ALU_MAX,  VEC_MODE16, 32'h8000_7fff, 32'h7fff_8000);
    add_row(ALU_MAXU, VEC_MODE16, 32'h8000_7fff, 32'h7fff_8000);
    add_row(ALU_MIN,  VEC_MODE32, 32'h8000_0000, 32'h0000_0001);
    add_row(ALU_MAXU, VEC_MODE32, 32'h8000_0000, 32'h0000_0001);
    // bitwise, mode must not matter
    add_row(ALU_AND, VEC_MODE8,  32'hf0f0_ff00, 32'hff00_0ff0);
    add_row(ALU_OR,  VEC_MODE16, 32'hf0f0_ff00, 32'h0f00_00ff);
    add_row(ALU_XOR, VEC_MODE32, 32'haaaa_5555, 32'hffff_0000);
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic build_random_rows();
    logic [31:0]               seed;
    logic [`SIMD_ALU_XLEN-1:0] a, b;
    alu_op_e                   op;
    vec_mode_e                 mode;
    int                        sel;
    seed = 32'h9b97;
    for (int i = 0; i < random_rows; i++) begin
      seed = lcg_next(seed);
      a    = seed;
      seed = lcg_next(seed);
      b    = seed;
      seed = lcg_next(seed);
      // upper lcg bits are the better ones
      op   = alu_op_e'(5'((seed >> 16) % 32'd21));
      sel  = int'((seed >> 24) % 32'd3);
      case (sel)
        0:       mode = VEC_MODE32;
        1:       mode = VEC_MODE16;
        default: mode = VEC_MODE8;
      endcase
      // now and then equal operands
      if (seed[31:29] == 3'd0) begin
        b = a;
      end
      add_row(op, mode, a, b);
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    int idles;
    arst_n_i      = 1'b0;
    enable_i      = 1'b0;
    operator_i    = ALU_ADD;
    vector_mode_i = VEC_MODE32;
    operand_a_i   = '0;
    operand_b_i   = '0;
    row_idx       = 0;
    current_row   = 0;
    checked       = 0;
    build_directed_rows();
    build_random_rows();
    idles         = rows.size() / idle_every;
    timeout_limit = reset_cycles + rows.size() + idles + 10;
    $display("applying %0d operations", rows.size());

    repeat (reset_cycles) @(posedge clk);
    arst_n_i <= 1'b1;

    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clk);
      enable_i      <= 1'b1;
      operator_i    <= rows[i].op;
      vector_mode_i <= rows[i].mode;
      operand_a_i   <= rows[i].a;
      operand_b_i   <= rows[i].b;
      row_idx       <= i;
      if (i % idle_every == idle_every - 1) begin
        @(posedge clk);
        enable_i <= 1'b0;
      end
    end
    @(posedge clk);
    enable_i <= 1'b0;

    // last result is due latency cycles after its enable
    repeat (latency + 1) @(posedge clk);
    if (pending.size() != 0) begin
      $display("%0d operations never produced a result", pending.size());
      abort_run();
    end else begin
      $display("%0d results checked", checked);
      $display("Everything OK");
      $finish;
    end
  end

  ////////////////////////////////////////
  // monitor and timeout
  ////////////////////////////////////////

  // outputs are read mid cycle where they are stable
  always @(negedge clk) begin
    pending_t entry;
    if (valid_o === 1'b1) begin
      if (pending.size() == 0) begin
        $display("valid_o was high at cycle %0d with no operation outstanding", cycle_cnt);
        abort_run();
      end else begin
        entry       = pending.pop_front();
        current_row = entry.row;
        if (cycle_cnt != entry.due) begin
          $display("result of row %0d came at cycle %0d instead of cycle %0d",
                   entry.row, cycle_cnt, entry.due);
          abort_run();
        end
        check_result("result_o", result_o, rows[entry.row].exp_result);
        if (rows[entry.row].flag_valid) begin
          check_flag("comparison_o", comparison_o, rows[entry.row].exp_flag);
        end
        checked = checked + 1;
      end
    end else if (valid_o !== 1'b0) begin
      $display("valid_o was unknown at cycle %0d", cycle_cnt);
      abort_run();
    end
    // the enable seen here was driven on the last rising edge
    if (enable_i === 1'b1 && arst_n_i === 1'b1) begin
      entry.row = row_idx;
      entry.due = cycle_cnt + latency;
      pending.push_back(entry);
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (timeout_limit != 0 && cycle_cnt >= timeout_limit) begin
      $display("run did not finish within %0d cycles", timeout_limit);
      abort_run();
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
+incdir+verification
source/simd_alu_pkg.sv
source/simd_alu_decode_stage.sv
source/simd_alu_execute_stage.sv
source/simd_alu_writeback_stage.sv
source/simd_alu_top.sv
verification/simd_alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the simd alu testbench with verilator, run it and judge the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f project.f --top-module simd_alu_tb -o simd_alu_sim
./obj_dir/simd_alu_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Something failed" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "Everything OK" sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi
echo "simulation passed"
